// File: Makefile
# Verilator build and run of the control FSM testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := zr_ctrl_tb
FILELIST := zr_ctrl.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/zr_ctrl_event_classify.sv
////////////////////////////////////////////////////////////////////////////
// stage one, ranks decoder reports into a single event and qualifies irqs
////////////////////////////////////////////////////////////////////////////

module zr_ctrl_event_classify (
  input  logic                 instr_valid_i,
  input  logic                 illegal_insn_i,
  input  logic                 ecall_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 ebrk_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,
  input  logic                 branch_in_id_i,
  input  logic                 instr_multicycle_i,
  input  logic                 irq_req_i,
  input  zr_ctrl_pkg::irq_id_t irq_id_i,
  input  logic                 m_ie_i,
  zr_ctrl_event_if.src         ev_o
);

  zr_ctrl_pkg::ctrl_event_e evt;
  // work in ID that must not be interrupted halfway
  logic                     busy_in_id;

  ////////////////////////////////////////////////////////////////////////////
  // decode event ranking
  ////////////////////////////////////////////////////////////////////////////

  // redirects win over flush-class events, same order as the
  // reference FSM so the flush cycle decodes the same winner
  always_comb begin
    evt = zr_ctrl_pkg::EV_NONE;
    if (instr_valid_i) begin
      if (branch_set_i) begin
        evt = zr_ctrl_pkg::EV_BRANCH;
      end else if (jump_set_i) begin
        evt = zr_ctrl_pkg::EV_JUMP;
      end else if (ecall_insn_i) begin
        evt = zr_ctrl_pkg::EV_ECALL;
      end else if (illegal_insn_i) begin
        evt = zr_ctrl_pkg::EV_ILLEGAL;
      end else if (mret_insn_i) begin
        evt = zr_ctrl_pkg::EV_MRET;
      end else if (ebrk_insn_i) begin
        evt = zr_ctrl_pkg::EV_EBREAK;
      end else if (pipe_flush_i) begin
        evt = zr_ctrl_pkg::EV_PIPE_FLUSH;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // interrupt qualification
  ////////////////////////////////////////////////////////////////////////////

  assign busy_in_id = instr_multicycle_i | branch_in_id_i;

  assign ev_o.valid          = instr_valid_i;
  assign ev_o.evt            = evt;
  assign ev_o.irq_pending    = irq_req_i & m_ie_i;
  // only insert between instructions, never inside a multicycle op
  assign ev_o.irq_insertable = irq_req_i & m_ie_i & ~busy_in_id;
  // masked request, the core still signals the kill
  assign ev_o.irq_killable   = irq_req_i & ~m_ie_i & ~busy_in_id;
  assign ev_o.irq_id         = irq_id_i;

  // decoder contract, a branch and a jump never resolve in one cycle
  a_branch_jump_excl : assert property (
    @(posedge ev_o.clk) disable iff (!ev_o.rst_n)
    !(branch_set_i && jump_set_i)
  ) else $error("branch_set_i and jump_set_i high together");

endmodule

// File: design/zr_ctrl_event_if.sv
////////////////////////////////////////////////////////////////////////////
// classified decode and interrupt events, classifier to sequencer/encoder
////////////////////////////////////////////////////////////////////////////

interface zr_ctrl_event_if (
  input logic clk,
  input logic rst_n
);

  // instruction in ID is valid this cycle
  logic                  valid;
  // ranked decode event, EV_NONE without a valid instruction
  zr_ctrl_pkg::ctrl_event_e evt;
  // request present and enabled in mstatus
  logic                  irq_pending;
  // pending and nothing in ID that must complete first
  logic                  irq_insertable;
  // request present but masked, current instruction may be killed
  logic                  irq_killable;
  zr_ctrl_pkg::irq_id_t  irq_id;

  // clk/rst_n only feed the assertions of the stages
  modport src (
    input  clk, rst_n,
    output valid, evt, irq_pending, irq_insertable, irq_killable, irq_id
  );

  modport dst (
    input  clk, rst_n,
    input  valid, evt, irq_pending, irq_insertable, irq_killable, irq_id
  );

endinterface

// File: design/zr_ctrl_params.svh
////////////////////////////////////////////////////////////////////////////
// widths and RISC-V trap cause codes for the core control FSM
// included by the package and by any stage that needs a raw cause code
////////////////////////////////////////////////////////////////////////////

`ifndef ZR_CTRL_PARAMS_SVH
`define ZR_CTRL_PARAMS_SVH

// interrupt identifier width, one id per fast interrupt line
`define ZR_IRQ_ID_W 5

// mcause width
// msb flags an interrupt, the rest holds the code or the irq id
`define ZR_CAUSE_W 6

////////////////////////////////////////////////////////////////////////////
// synchronous exception causes (privileged spec, machine mode)
////////////////////////////////////////////////////////////////////////////

// decoder could not make sense of the opcode
`define ZR_CAUSE_ILLEGAL 6'd2

// ebreak, no debug unit so it traps like any other exception
`define ZR_CAUSE_BREAK 6'd3

// environment call from M-mode
`define ZR_CAUSE_ECALL_M 6'd11

`endif

// File: design/zr_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the control FSM, referenced by scoped name only
////////////////////////////////////////////////////////////////////////////

`include "zr_ctrl_params.svh"

package zr_ctrl_pkg;

  // interrupt number as delivered by the interrupt controller
  typedef logic [`ZR_IRQ_ID_W-1:0] irq_id_t;

  // mcause style value, msb set for interrupts
  typedef logic [`ZR_CAUSE_W-1:0] cause_t;

  // pc source select towards the fetch stage
  // gaps in the encoding belong to the debug targets of the full core
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_sel_e;

  // exception vector select, picks the handler entry
  typedef enum logic [1:0] {
    EXC_PC_IRQ     = 2'd0,
    EXC_PC_ILLINSN = 2'd1,
    EXC_PC_ECALL   = 2'd2,
    EXC_PC_BREAK   = 2'd3
  } exc_pc_sel_e;

  // one decode event per cycle, already ranked by the classifier
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BRANCH,
    EV_JUMP,
    EV_ECALL,
    EV_ILLEGAL,
    EV_MRET,
    EV_EBREAK,
    EV_PIPE_FLUSH
  } ctrl_event_e;

  // main control FSM states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

endpackage

// File: design/zr_ctrl_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// stage two, control state register with halt, fetch and busy outputs
////////////////////////////////////////////////////////////////////////////

module zr_ctrl_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,
  input  logic                     id_ready_i,
  input  logic                     irq_req_i,
  zr_ctrl_event_if.dst             ev_i,
  output zr_ctrl_pkg::ctrl_state_e state_o,
  output logic                     instr_req_o,
  output logic                     ctrl_busy_o,
  output logic                     first_fetch_o,
  output logic                     is_decoding_o,
  output logic                     deassert_we_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     exc_kill_o,
  output logic                     perf_jump_o,
  output logic                     perf_tbranch_o
);

  zr_ctrl_pkg::ctrl_state_e state_q;
  zr_ctrl_pkg::ctrl_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state and per-state outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    instr_req_o    = 1'b1;
    ctrl_busy_o    = 1'b1;
    first_fetch_o  = 1'b0;
    is_decoding_o  = 1'b0;
    halt_if_o      = 1'b0;
    halt_id_o      = 1'b0;
    exc_kill_o     = 1'b0;
    perf_jump_o    = 1'b0;
    perf_tbranch_o = 1'b0;

    unique case (state_q)
      // idle until software enables fetching
      zr_ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = zr_ctrl_pkg::BOOT_SET;
        end
      end
      // boot address goes out this cycle, see encoder
      zr_ctrl_pkg::BOOT_SET: begin
        state_d = zr_ctrl_pkg::FIRST_FETCH;
      end
      // one cycle to let the pipe drain before sleeping
      zr_ctrl_pkg::WAIT_SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = zr_ctrl_pkg::SLEEP;
      end
      // wake on fetch enable or any irq request, even a masked one
      zr_ctrl_pkg::SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = zr_ctrl_pkg::FIRST_FETCH;
        end
      end
      // wait for the first instruction, pipe is known empty here
      zr_ctrl_pkg::FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = zr_ctrl_pkg::DECODE;
        end
        if (ev_i.irq_pending) begin
          state_d   = zr_ctrl_pkg::IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end
      zr_ctrl_pkg::DECODE: begin
        if (ev_i.valid) begin
          is_decoding_o = 1'b1;
          unique case (ev_i.evt)
            zr_ctrl_pkg::EV_BRANCH: perf_tbranch_o = 1'b1;
            zr_ctrl_pkg::EV_JUMP:   perf_jump_o    = 1'b1;
            zr_ctrl_pkg::EV_NONE: begin
              if (ev_i.irq_insertable) begin
                state_d   = zr_ctrl_pkg::IRQ_TAKEN;
                halt_if_o = 1'b1;
                halt_id_o = 1'b1;
              end else begin
                exc_kill_o = ev_i.irq_killable;
              end
            end
            // every remaining event is flush class
            default: begin
              state_d   = zr_ctrl_pkg::FLUSH;
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
            end
          endcase
        end else if (ev_i.irq_pending) begin
          // empty ID stage, irq can go in right away
          state_d   = zr_ctrl_pkg::IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end
      // redirect cycle, ID holds the flushing instruction
      zr_ctrl_pkg::FLUSH: begin
        halt_if_o = ~fetch_enable_i;
        halt_id_o = 1'b1;
        if (!fetch_enable_i && (ev_i.evt == zr_ctrl_pkg::EV_MRET ||
                                ev_i.evt == zr_ctrl_pkg::EV_PIPE_FLUSH)) begin
          state_d = zr_ctrl_pkg::WAIT_SLEEP;
        end else begin
          state_d = zr_ctrl_pkg::DECODE;
        end
      end
      // vector jump happens here, back to decoding the handler
      zr_ctrl_pkg::IRQ_TAKEN: begin
        state_d = zr_ctrl_pkg::DECODE;
      end
    endcase
  end

  // no write back unless a legal instruction is being decoded
  assign deassert_we_o = ~is_decoding_o | (ev_i.evt == zr_ctrl_pkg::EV_ILLEGAL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= zr_ctrl_pkg::RESET;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // ID is never frozen on its own edge while IF keeps fetching
  a_halt_order : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(halt_id_o) |-> halt_if_o
  ) else $error("halt_id_o rose without halt_if_o");

endmodule

// File: design/zr_ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// core control FSM top, classifier -> sequencer -> trap encoder
// all outputs are combinational from the state and the current inputs
////////////////////////////////////////////////////////////////////////////

module zr_ctrl_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,
  input  logic                     instr_valid_i,
  input  logic                     illegal_insn_i,
  input  logic                     ecall_insn_i,
  input  logic                     mret_insn_i,
  input  logic                     ebrk_insn_i,
  input  logic                     pipe_flush_i,
  input  logic                     branch_set_i,
  input  logic                     jump_set_i,
  input  logic                     branch_in_id_i,
  input  logic                     instr_multicycle_i,
  input  logic                     id_ready_i,
  input  logic                     irq_req_i,
  input  zr_ctrl_pkg::irq_id_t     irq_id_i,
  input  logic                     m_ie_i,
  output logic                     instr_req_o,
  output logic                     ctrl_busy_o,
  output logic                     first_fetch_o,
  output logic                     is_decoding_o,
  output logic                     deassert_we_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     exc_kill_o,
  output logic                     perf_jump_o,
  output logic                     perf_tbranch_o,
  output logic                     pc_set_o,
  output zr_ctrl_pkg::pc_sel_e     pc_mux_o,
  output zr_ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
  output zr_ctrl_pkg::cause_t      exc_cause_o,
  output logic                     exc_ack_o,
  output logic                     irq_ack_o,
  output zr_ctrl_pkg::irq_id_t     irq_id_o,
  output logic                     csr_save_if_o,
  output logic                     csr_save_id_o,
  output logic                     csr_save_cause_o,
  output zr_ctrl_pkg::cause_t      csr_cause_o,
  output logic                     csr_restore_mret_id_o
);

  // state of the sequencer, read by the encoder
  zr_ctrl_pkg::ctrl_state_e state;

  zr_ctrl_event_if ev_if (
    .clk   (clk),
    .rst_n (rst_n)
  );

  zr_ctrl_event_classify u_classify (
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_i),
    .ecall_insn_i       (ecall_insn_i),
    .mret_insn_i        (mret_insn_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .branch_in_id_i     (branch_in_id_i),
    .instr_multicycle_i (instr_multicycle_i),
    .irq_req_i          (irq_req_i),
    .irq_id_i           (irq_id_i),
    .m_ie_i             (m_ie_i),
    .ev_o               (ev_if.src)
  );

  zr_ctrl_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready_i),
    .irq_req_i      (irq_req_i),
    .ev_i           (ev_if.dst),
    .state_o        (state),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .deassert_we_o  (deassert_we_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .exc_kill_o     (exc_kill_o),
    .perf_jump_o    (perf_jump_o),
    .perf_tbranch_o (perf_tbranch_o)
  );

  zr_ctrl_trap_encode u_trap_encode (
    .state_i               (state),
    .ev_i                  (ev_if.dst),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (exc_cause_o),
    .exc_ack_o             (exc_ack_o),
    .irq_ack_o             (irq_ack_o),
    .irq_id_o              (irq_id_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_cause_o           (csr_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o)
  );

endmodule

// File: design/zr_ctrl_trap_encode.sv
////////////////////////////////////////////////////////////////////////////
// stage three, turns state and event into pc redirect, causes, csr strobes
////////////////////////////////////////////////////////////////////////////

`include "zr_ctrl_params.svh"

module zr_ctrl_trap_encode (
  input  zr_ctrl_pkg::ctrl_state_e state_i,
  zr_ctrl_event_if.dst             ev_i,
  output logic                     pc_set_o,
  output zr_ctrl_pkg::pc_sel_e     pc_mux_o,
  output zr_ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
  output zr_ctrl_pkg::cause_t      exc_cause_o,
  output logic                     exc_ack_o,
  output logic                     irq_ack_o,
  output zr_ctrl_pkg::irq_id_t     irq_id_o,
  output logic                     csr_save_if_o,
  output logic                     csr_save_id_o,
  output logic                     csr_save_cause_o,
  output zr_ctrl_pkg::cause_t      csr_cause_o,
  output logic                     csr_restore_mret_id_o
);

  always_comb begin
    pc_set_o              = 1'b0;
    pc_mux_o              = zr_ctrl_pkg::PC_BOOT;
    exc_pc_mux_o          = zr_ctrl_pkg::EXC_PC_IRQ;
    exc_cause_o           = '0;
    exc_ack_o             = 1'b0;
    irq_ack_o             = 1'b0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_cause_o           = '0;
    csr_restore_mret_id_o = 1'b0;

    unique case (state_i)
      zr_ctrl_pkg::BOOT_SET: begin
        pc_set_o = 1'b1;
      end
      // taken branch or jump, target comes from the ID stage adder
      zr_ctrl_pkg::DECODE: begin
        if (ev_i.evt == zr_ctrl_pkg::EV_BRANCH || ev_i.evt == zr_ctrl_pkg::EV_JUMP) begin
          pc_set_o = 1'b1;
          pc_mux_o = zr_ctrl_pkg::PC_JUMP;
        end
      end
      // mepc gets the IF pc, mcause the id with the interrupt bit
      zr_ctrl_pkg::IRQ_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = zr_ctrl_pkg::PC_EXCEPTION;
        exc_pc_mux_o     = zr_ctrl_pkg::EXC_PC_IRQ;
        exc_cause_o      = {1'b0, ev_i.irq_id};
        csr_cause_o      = {1'b1, ev_i.irq_id};
        csr_save_cause_o = 1'b1;
        csr_save_if_o    = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
      end
      zr_ctrl_pkg::FLUSH: begin
        unique case (ev_i.evt)
          zr_ctrl_pkg::EV_ECALL: begin
            exc_pc_mux_o = zr_ctrl_pkg::EXC_PC_ECALL;
            exc_cause_o  = `ZR_CAUSE_ECALL_M;
          end
          zr_ctrl_pkg::EV_ILLEGAL: begin
            exc_pc_mux_o = zr_ctrl_pkg::EXC_PC_ILLINSN;
            exc_cause_o  = `ZR_CAUSE_ILLEGAL;
          end
          zr_ctrl_pkg::EV_EBREAK: begin
            exc_pc_mux_o = zr_ctrl_pkg::EXC_PC_BREAK;
            exc_cause_o  = `ZR_CAUSE_BREAK;
          end
          zr_ctrl_pkg::EV_MRET: begin
            pc_set_o              = 1'b1;
            pc_mux_o              = zr_ctrl_pkg::PC_ERET;
            csr_restore_mret_id_o = 1'b1;
          end
          // pipe flush just refetches, nothing to redirect
          default: ;
        endcase
        // shared tail of the three synchronous exceptions, mepc from ID
        if (ev_i.evt inside {zr_ctrl_pkg::EV_ECALL, zr_ctrl_pkg::EV_ILLEGAL,
                             zr_ctrl_pkg::EV_EBREAK}) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = zr_ctrl_pkg::PC_EXCEPTION;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          csr_cause_o      = exc_cause_o;
        end
      end
      default: ;
    endcase
  end

  assign irq_id_o = ev_i.irq_id;

  // an acknowledged trap always lands on the exception vector
  a_ack_redirects : assert property (
    @(posedge ev_i.clk) disable iff (!ev_i.rst_n)
    exc_ack_o |-> (pc_set_o && pc_mux_o == zr_ctrl_pkg::PC_EXCEPTION)
  ) else $error("exc_ack_o without an exception redirect");

endmodule

// File: tb/zr_ctrl_golden.txt
# name  in: fe iv il ec mr eb pf bs js bi mc rdy rq ie  irq_id (ff is filler)
# exp: req busy ff dec we hif hid kill pj pt pcs eack iack sif sid scs rst  pc vec exc csr
reset_idle     00000000000000 ff 00001000000000000 0 0 00 00
reset_hold     00000000000000 ff 00001000000000000 0 0 00 00
boot_enable    10000000000000 ff 00001000000000000 0 0 00 00
boot_set       10000000000000 ff 11001000001000000 0 0 00 00
first_wait0    10000000000000 ff 11101000000000000 0 0 00 00
first_wait1    10000000000000 ff 11101000000000000 0 0 00 00
first_ready    10000000000100 ff 11101000000000000 0 0 00 00
decode_idle    10000000000000 ff 11001000000000000 0 0 00 00
branch         11000001000000 ff 11010000011000000 2 0 00 00
jump           11000000100000 ff 11010000101000000 2 0 00 00
ecall_report   11010000000000 ff 11010110000000000 0 0 00 00
ecall_flush    11010000000000 ff 11001010001000110 4 2 0b 0b
ecall_resume   10000000000000 ff 11001000000000000 0 0 00 00
illegal_report 11100000000000 ff 11011110000000000 0 0 00 00
illegal_flush  11100000000000 ff 11001010001000110 4 1 02 02
illegal_resume 10000000000000 ff 11001000000000000 0 0 00 00
ebreak_report  11000100000000 ff 11010110000000000 0 0 00 00
ebreak_flush   11000100000000 ff 11001010001000110 4 3 03 03
ebreak_resume  10000000000000 ff 11001000000000000 0 0 00 00
mret_report    01001000000000 ff 11010110000000000 0 0 00 00
mret_flush     01001000000000 ff 11001110001000001 5 0 00 00
wait_sleep     00000000000000 ff 00001110000000000 0 0 00 00
sleep          00000000000000 ff 00001110000000000 0 0 00 00
sleep_wake     00000000000010 07 00001110000000000 0 0 00 00
wake_fetch     10000000000100 ff 11101000000000000 0 0 00 00
wake_decode    10000000000000 ff 11001000000000000 0 0 00 00
irq_request    10000000000011 0a 11001110000000000 0 0 00 00
irq_taken      10000000000011 0a 11001000001111010 4 0 0a 2a
irq_resume     10000000000000 ff 11001000000000000 0 0 00 00
irq_kill       11000000000010 05 11010001000000000 0 0 00 00
kill_in_mc     11000000001010 05 11010000000000000 0 0 00 00
irq_in_branch  11000000010011 0c 11010000000000000 0 0 00 00
flush_report   11000010000000 ff 11010110000000000 0 0 00 00
flush_refetch  11000010000000 ff 11001010000000000 0 0 00 00
flush_resume   10000000000000 ff 11001000000000000 0 0 00 00

// File: tb/zr_ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the core control FSM, replays per-cycle golden vectors
// inputs go in 10 ns after the rising edge, outputs are checked at 90 ns
////////////////////////////////////////////////////////////////////////////

module zr_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam string GOLDEN_PATH    = "tb/zr_ctrl_golden.txt";
  localparam int    CLK_HALF       = 50;
  localparam int    RESET_CYCLES   = 16;
  localparam int    TIMEOUT_MARGIN = 20;

  logic                     clk;
  logic                     rst_n;
  logic                     fetch_enable_i;
  logic                     instr_valid_i;
  logic                     illegal_insn_i;
  logic                     ecall_insn_i;
  logic                     mret_insn_i;
  logic                     ebrk_insn_i;
  logic                     pipe_flush_i;
  logic                     branch_set_i;
  logic                     jump_set_i;
  logic                     branch_in_id_i;
  logic                     instr_multicycle_i;
  logic                     id_ready_i;
  logic                     irq_req_i;
  zr_ctrl_pkg::irq_id_t     irq_id_i;
  logic                     m_ie_i;
  logic                     instr_req_o;
  logic                     ctrl_busy_o;
  logic                     first_fetch_o;
  logic                     is_decoding_o;
  logic                     deassert_we_o;
  logic                     halt_if_o;
  logic                     halt_id_o;
  logic                     exc_kill_o;
  logic                     perf_jump_o;
  logic                     perf_tbranch_o;
  logic                     pc_set_o;
  zr_ctrl_pkg::pc_sel_e     pc_mux_o;
  zr_ctrl_pkg::exc_pc_sel_e exc_pc_mux_o;
  zr_ctrl_pkg::cause_t      exc_cause_o;
  logic                     exc_ack_o;
  logic                     irq_ack_o;
  zr_ctrl_pkg::irq_id_t     irq_id_o;
  logic                     csr_save_if_o;
  logic                     csr_save_id_o;
  logic                     csr_save_cause_o;
  zr_ctrl_pkg::cause_t      csr_cause_o;
  logic                     csr_restore_mret_id_o;

  // one entry per golden line
  string       name_q[$];
  logic [13:0] stim_q[$];
  logic [7:0]  id_q[$];
  logic [16:0] flag_q[$];
  logic [2:0]  pc_q[$];
  logic [1:0]  exc_pc_q[$];
  logic [5:0]  exc_cause_q[$];
  logic [5:0]  csr_cause_q[$];

  int mismatch_cnt  = 0;
  int other_err_cnt = 0;
  int cycle_cnt     = 0;
  int timeout_cycles = RESET_CYCLES + TIMEOUT_MARGIN;

  zr_ctrl_top dut_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .fetch_enable_i        (fetch_enable_i),
    .instr_valid_i         (instr_valid_i),
    .illegal_insn_i        (illegal_insn_i),
    .ecall_insn_i          (ecall_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .pipe_flush_i          (pipe_flush_i),
    .branch_set_i          (branch_set_i),
    .jump_set_i            (jump_set_i),
    .branch_in_id_i        (branch_in_id_i),
    .instr_multicycle_i    (instr_multicycle_i),
    .id_ready_i            (id_ready_i),
    .irq_req_i             (irq_req_i),
    .irq_id_i              (irq_id_i),
    .m_ie_i                (m_ie_i),
    .instr_req_o           (instr_req_o),
    .ctrl_busy_o           (ctrl_busy_o),
    .first_fetch_o         (first_fetch_o),
    .is_decoding_o         (is_decoding_o),
    .deassert_we_o         (deassert_we_o),
    .halt_if_o             (halt_if_o),
    .halt_id_o             (halt_id_o),
    .exc_kill_o            (exc_kill_o),
    .perf_jump_o           (perf_jump_o),
    .perf_tbranch_o        (perf_tbranch_o),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (exc_cause_o),
    .exc_ack_o             (exc_ack_o),
    .irq_ack_o             (irq_ack_o),
    .irq_id_o              (irq_id_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_cause_o           (csr_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o)
  );

  initial clk = 1'b0;
  always #(CLK_HALF) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // typed compare tasks, one per kind of result
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_flag(input string test, input string sig, input logic exp,
                            input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: %s expected %0b actual %0b", test, sig, exp, act);
    end
  endtask

  task automatic check_pc(input string test, input zr_ctrl_pkg::pc_sel_e exp,
                          input zr_ctrl_pkg::pc_sel_e act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: pc_mux expected %0d actual %0d", test, exp, act);
    end
  endtask

  task automatic check_exc_pc(input string test, input zr_ctrl_pkg::exc_pc_sel_e exp,
                              input zr_ctrl_pkg::exc_pc_sel_e act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: exc_pc_mux expected %0d actual %0d", test, exp, act);
    end
  endtask

  task automatic check_cause(input string test, input string sig,
                             input zr_ctrl_pkg::cause_t exp, input zr_ctrl_pkg::cause_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: %s expected 0x%h actual 0x%h", test, sig, exp, act);
    end
  endtask

  task automatic check_irq_id(input string test, input zr_ctrl_pkg::irq_id_t exp,
                              input zr_ctrl_pkg::irq_id_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: irq_id expected 0x%h actual 0x%h", test, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // golden file reader, stimulus and per-cycle checks
  ////////////////////////////////////////////////////////////////////////////

  // columns: name, input bits, irq id, expected flags, pc, vector, causes
  task automatic read_golden();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [13:0] stim;
    logic [7:0]  id;
    logic [16:0] flags;
    logic [2:0]  pc;
    logic [1:0]  epc;
    logic [5:0]  ec;
    logic [5:0]  cc;
    fd = $fopen(GOLDEN_PATH, "r");
    if (fd == 0) begin
      other_err_cnt++;
      $display("could not open the golden vector file %s", GOLDEN_PATH);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %b %h %b %h %h %h %h", name, stim, id, flags, pc, epc, ec, cc);
      if (n != 8) begin
        other_err_cnt++;
        $display("golden line could not be parsed: %s", line);
        continue;
      end
      name_q.push_back(name);
      stim_q.push_back(stim);
      id_q.push_back(id);
      flag_q.push_back(flags);
      pc_q.push_back(pc);
      exc_pc_q.push_back(epc);
      exc_cause_q.push_back(ec);
      csr_cause_q.push_back(cc);
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      other_err_cnt++;
      $display("the golden vector file holds no vectors");
    end
  endtask

  // bit order fe iv il ec mr eb pf bs js bi mc rdy rq ie, msb first
  task automatic apply_vector(input logic [13:0] stim, input logic [7:0] id);
    int unsigned filler;
    fetch_enable_i     = stim[13];
    instr_valid_i      = stim[12];
    illegal_insn_i     = stim[11];
    ecall_insn_i       = stim[10];
    mret_insn_i        = stim[9];
    ebrk_insn_i        = stim[8];
    pipe_flush_i       = stim[7];
    branch_set_i       = stim[6];
    jump_set_i         = stim[5];
    branch_in_id_i     = stim[4];
    instr_multicycle_i = stim[3];
    id_ready_i         = stim[2];
    irq_req_i          = stim[1];
    m_ie_i             = stim[0];
    // ids above the 5 bit range mean the id is a don't care
    if (id > 8'd31) begin
      filler   = $urandom_range(31, 0);
      irq_id_i = filler[4:0];
    end else begin
      irq_id_i = id[4:0];
    end
  endtask

  task automatic check_outputs(input int idx);
    string       test;
    logic [16:0] f;
    logic [7:0]  id;
    test = name_q[idx];
    f    = flag_q[idx];
    id   = id_q[idx];
    check_flag(test, "instr_req", f[16], instr_req_o);
    check_flag(test, "ctrl_busy", f[15], ctrl_busy_o);
    check_flag(test, "first_fetch", f[14], first_fetch_o);
    check_flag(test, "is_decoding", f[13], is_decoding_o);
    check_flag(test, "deassert_we", f[12], deassert_we_o);
    check_flag(test, "halt_if", f[11], halt_if_o);
    check_flag(test, "halt_id", f[10], halt_id_o);
    check_flag(test, "exc_kill", f[9], exc_kill_o);
    check_flag(test, "perf_jump", f[8], perf_jump_o);
    check_flag(test, "perf_tbranch", f[7], perf_tbranch_o);
    check_flag(test, "pc_set", f[6], pc_set_o);
    check_flag(test, "exc_ack", f[5], exc_ack_o);
    check_flag(test, "irq_ack", f[4], irq_ack_o);
    check_flag(test, "csr_save_if", f[3], csr_save_if_o);
    check_flag(test, "csr_save_id", f[2], csr_save_id_o);
    check_flag(test, "csr_save_cause", f[1], csr_save_cause_o);
    check_flag(test, "csr_restore_mret", f[0], csr_restore_mret_id_o);
    check_pc(test, zr_ctrl_pkg::pc_sel_e'(pc_q[idx]), pc_mux_o);
    check_exc_pc(test, zr_ctrl_pkg::exc_pc_sel_e'(exc_pc_q[idx]), exc_pc_mux_o);
    check_cause(test, "exc_cause", exc_cause_q[idx], exc_cause_o);
    check_cause(test, "csr_cause", csr_cause_q[idx], csr_cause_o);
    // a real id in the golden line is the id expected back, filler leaves it open
    if (id <= 8'd31) begin
      check_irq_id(test, id[4:0], irq_id_o);
    end
  endtask

  task automatic print_counts();
    $display("error counts: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
  endtask

  // run limit, long enough for reset plus every golden cycle
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(24648));
    rst_n = 1'b0;
    apply_vector('0, 8'd0);
    read_golden();
    timeout_cycles = timeout_cycles + name_q.size();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    // reset drops with the first vector, 16 rising edges after start
    foreach (name_q[i]) begin
      @(posedge clk);
      #10;
      rst_n = 1'b1;
      apply_vector(stim_q[i], id_q[i]);
      #80;
      check_outputs(i);
    end
    print_counts();
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: zr_ctrl.f
+incdir+design
design/zr_ctrl_pkg.sv
design/zr_ctrl_event_if.sv
design/zr_ctrl_event_classify.sv
design/zr_ctrl_sequencer.sv
design/zr_ctrl_trap_encode.sv
design/zr_ctrl_top.sv
tb/zr_ctrl_tb.sv
